// ==== hdl/fir_pkg.sv ====
// widths, register offsets, tap limit and state enums for the FIR filter
package fir_pkg;

  // lite byte address
  typedef logic [11:0] addr_t;
  // lite data word, sample, coefficient and filter output
  typedef logic [31:0] data_t;
  // index into the coefficient store or the sample ring
  typedef logic [4:0]  tap_idx_t;

  // depth of both memories
  localparam int MAX_TAPS = 32;

  // register map
  localparam addr_t AP_CTRL_ADDR  = 12'h000;
  localparam addr_t DATA_LEN_ADDR = 12'h010;
  localparam addr_t COEF_LEN_ADDR = 12'h014;
  localparam addr_t TAP_BASE_ADDR = 12'h080;
  localparam addr_t TAP_LAST_ADDR = 12'h0FC;

  // ap_ctrl bit positions
  localparam int AP_START_BIT = 0;
  localparam int AP_DONE_BIT  = 1;
  localparam int AP_IDLE_BIT  = 2;

  // run status seen by the host
  typedef enum logic [1:0] {
    RUN_IDLE,
    RUN_BUSY,
    RUN_DONE
  } run_state_e;

  // sample engine
  typedef enum logic [2:0] {
    ENG_OFF,
    ENG_WAIT_SAMPLE,
    ENG_MAC,
    ENG_DRAIN,
    ENG_OUT
  } eng_state_e;

endpackage

// ==== hdl/fir_ram_if.sv ====
// interface for one write port and one synchronous read port of a memory
`timescale 1ns/10ps

interface fir_ram_if import fir_pkg::*; ();

  // write port
  logic     we;
  tap_idx_t waddr;
  data_t    wdata;

  // read port, rdata follows raddr by one cycle
  tap_idx_t raddr;
  data_t    rdata;

  modport user (
    output we, waddr, wdata,
    output raddr,
    input  rdata
  );

  modport mem (
    input  we, waddr, wdata,
    input  raddr,
    output rdata
  );

endinterface

// ==== hdl/fir_ctrl_if.sv ====
// interface for run configuration and start/done between register block and engine
`timescale 1ns/10ps

interface fir_ctrl_if import fir_pkg::*; ();

  // one-cycle pulse, run begins
  logic  start;
  // held by the register block for the whole run
  data_t coef_length;
  data_t data_length;
  // one-cycle pulse after the last output handshake
  logic  done;

  modport regs (
    output start,
    output coef_length,
    output data_length,
    input  done
  );

  modport engine (
    input  start,
    input  coef_length,
    input  data_length,
    output done
  );

endinterface

// ==== hdl/fir_ram.sv ====
// simple dual-port memory with one-cycle read latency
`timescale 1ns/10ps

module fir_ram import fir_pkg::*; (
  input logic    axis_clk,
  fir_ram_if.mem port
);

  // storage, no reset on the array
  data_t mem_q [MAX_TAPS];

  // write on we
  always_ff @(posedge axis_clk) begin
    if (port.we) begin
      mem_q[port.waddr] <= port.wdata;
    end
  end

  // registered read
  // a same-address write in this cycle is not seen until the next read
  always_ff @(posedge axis_clk) begin
    port.rdata <= mem_q[port.raddr];
  end

endmodule

// ==== hdl/fir_axil_regs.sv ====
// lite write/read channels, configuration registers, ap_ctrl status and coefficient writes
`timescale 1ns/10ps

module fir_axil_regs import fir_pkg::*; (
  input  logic        axis_clk,
  input  logic        axis_rst_n,
  input  logic        awvalid,
  input  logic        wvalid,
  input  logic        arvalid,
  input  logic        rready,
  input  addr_t       awaddr,
  input  addr_t       araddr,
  input  data_t       wdata,
  output logic        awready,
  output logic        wready,
  output logic        arready,
  output logic        rvalid,
  output data_t       rdata,
  fir_ram_if.user     coef,
  fir_ctrl_if.regs    ctrl
);

  run_state_e run_state;
  data_t      coef_len;
  data_t      data_len;

  logic  w_ready;
  logic  wr_fire;
  logic  wr_tap;
  logic  is_idle;

  logic  ar_ready;
  logic  r_valid;
  logic  rd_clr;
  logic  ar_fire;
  logic  r_fire;
  data_t ctrl_word;
  data_t rd_word;

  assign is_idle = (run_state == RUN_IDLE);

  // write channel
  // both valids seen, ready pulses one cycle later
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      w_ready <= 1'b0;
    end else begin
      w_ready <= awvalid && wvalid && !w_ready;
    end
  end

  assign awready = w_ready;
  assign wready  = w_ready;
  assign wr_fire = w_ready && awvalid && wvalid;
  assign wr_tap  = (awaddr >= TAP_BASE_ADDR) && (awaddr <= TAP_LAST_ADDR);

  // coefficient store, write side only
  assign coef.we    = wr_fire && wr_tap && is_idle;
  assign coef.waddr = tap_idx_t'((awaddr - TAP_BASE_ADDR) >> 2);
  assign coef.wdata = wdata;

  // run begins on a write of ap_start while idle
  assign ctrl.start = wr_fire && (awaddr == AP_CTRL_ADDR) && wdata[AP_START_BIT] && is_idle;

  // configuration, frozen outside idle
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      coef_len <= '0;
      data_len <= '0;
    end else if (wr_fire && is_idle) begin
      if (awaddr == COEF_LEN_ADDR) begin
        coef_len <= wdata;
      end
      if (awaddr == DATA_LEN_ADDR) begin
        data_len <= wdata;
      end
    end
  end

  assign ctrl.coef_length = coef_len;
  assign ctrl.data_length = data_len;

  // run status
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      run_state <= RUN_IDLE;
    end else begin
      case (run_state)
        RUN_IDLE: if (ctrl.start) run_state <= RUN_BUSY;
        RUN_BUSY: if (ctrl.done) run_state <= RUN_DONE;
        RUN_DONE: if (r_fire && rd_clr) run_state <= RUN_IDLE;
        default:  run_state <= RUN_IDLE;
      endcase
    end
  end

  // read channel, one read in flight
  assign ar_fire = ar_ready && arvalid;
  assign r_fire  = r_valid && rready;

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      ar_ready <= 1'b0;
      r_valid  <= 1'b0;
      rd_clr   <= 1'b0;
    end else begin
      ar_ready <= arvalid && !ar_ready && !r_valid;
      if (ar_fire) begin
        r_valid <= 1'b1;
        // only a read that returned done may clear it
        rd_clr  <= (araddr == AP_CTRL_ADDR) && (run_state == RUN_DONE);
      end else if (r_fire) begin
        r_valid <= 1'b0;
        rd_clr  <= 1'b0;
      end
    end
  end

  assign arready = ar_ready;
  assign rvalid  = r_valid;

  // status word, ap_start reads back as 0
  always_comb begin
    ctrl_word = '0;
    ctrl_word[AP_DONE_BIT] = (run_state == RUN_DONE);
    ctrl_word[AP_IDLE_BIT] = (run_state == RUN_IDLE);
  end

  // address decode, tap window reads as zero
  always_comb begin
    case (araddr)
      AP_CTRL_ADDR:  rd_word = ctrl_word;
      DATA_LEN_ADDR: rd_word = data_len;
      COEF_LEN_ADDR: rd_word = coef_len;
      default:       rd_word = '0;
    endcase
  end

  // read data held until rready
  always_ff @(posedge axis_clk) begin
    if (ar_fire) begin
      rdata <= rd_word;
    end
  end

endmodule

// ==== hdl/fir_mac_engine.sv ====
// sample intake, ring addressing, multiply-accumulate loop and output hold
`timescale 1ns/10ps

module fir_mac_engine import fir_pkg::*; (
  input  logic        axis_clk,
  input  logic        axis_rst_n,
  input  logic        ss_tvalid,
  input  logic        sm_tready,
  input  data_t       ss_tdata,
  output logic        ss_tready,
  output logic        sm_tvalid,
  output logic        sm_tlast,
  output data_t       sm_tdata,
  fir_ram_if.user     coef,
  fir_ram_if.user     samples,
  fir_ctrl_if.engine  ctrl
);

  eng_state_e state;

  // ring pointers and tap index
  tap_idx_t   wr_ptr;
  tap_idx_t   head;
  tap_idx_t   k;
  tap_idx_t   last_tap;
  // samples taken in since start, also the output number
  data_t      taken_cnt;
  logic [1:0] drain_cnt;

  // read, product and sum stages
  logic       rd_vld;
  logic       rd_skip;
  logic       prod_vld;
  data_t      prod;
  data_t      acc;

  logic       in_fire;
  logic       out_fire;

  // stream handshakes
  assign ss_tready = (state == ENG_WAIT_SAMPLE);
  assign sm_tvalid = (state == ENG_OUT);
  assign in_fire   = ss_tvalid && ss_tready;
  assign out_fire  = sm_tvalid && sm_tready;
  assign sm_tdata  = acc;
  assign sm_tlast  = sm_tvalid && (taken_cnt == ctrl.data_length);

  // clamp the tap count to the memory depth
  assign last_tap = (ctrl.coef_length > data_t'(MAX_TAPS)) ?
                    tap_idx_t'(MAX_TAPS - 1) : tap_idx_t'(ctrl.coef_length - 1);

  // sample ring, write at intake, read newest first
  assign samples.we    = in_fire;
  assign samples.waddr = wr_ptr;
  assign samples.wdata = ss_tdata;
  assign samples.raddr = head - k;

  // coefficient k pairs with sample n-k
  assign coef.raddr = k;

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state     <= ENG_OFF;
      wr_ptr    <= '0;
      head      <= '0;
      k         <= '0;
      taken_cnt <= '0;
      drain_cnt <= '0;
      ctrl.done <= 1'b0;
    end else begin
      ctrl.done <= 1'b0;
      case (state)
        ENG_OFF: begin
          // history starts fresh on every run
          if (ctrl.start) begin
            wr_ptr    <= '0;
            taken_cnt <= '0;
            state     <= ENG_WAIT_SAMPLE;
          end
        end
        ENG_WAIT_SAMPLE: begin
          if (in_fire) begin
            head      <= wr_ptr;
            wr_ptr    <= wr_ptr + 1'b1;
            taken_cnt <= taken_cnt + 1'b1;
            k         <= '0;
            state     <= ENG_MAC;
          end
        end
        ENG_MAC: begin
          if (k == last_tap) begin
            drain_cnt <= '0;
            state     <= ENG_DRAIN;
          end else begin
            k <= k + 1'b1;
          end
        end
        ENG_DRAIN: begin
          // let the read, product and sum stages empty
          if (drain_cnt == 2'd2) begin
            state <= ENG_OUT;
          end else begin
            drain_cnt <= drain_cnt + 1'b1;
          end
        end
        ENG_OUT: begin
          if (out_fire) begin
            if (sm_tlast) begin
              ctrl.done <= 1'b1;
              state     <= ENG_OFF;
            end else begin
              state <= ENG_WAIT_SAMPLE;
            end
          end
        end
        default: state <= ENG_OFF;
      endcase
    end
  end

  // stage valids
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      rd_vld   <= 1'b0;
      prod_vld <= 1'b0;
    end else begin
      rd_vld   <= (state == ENG_MAC);
      prod_vld <= rd_vld;
    end
  end

  // taps reaching back past the first sample add nothing
  always_ff @(posedge axis_clk) begin
    rd_skip <= (data_t'(k) >= taken_cnt);
    if (rd_vld) begin
      prod <= rd_skip ? '0 : coef.rdata * samples.rdata;
    end
    if (in_fire) begin
      acc <= '0;
    end else if (prod_vld) begin
      acc <= acc + prod;
    end
  end

endmodule

// ==== hdl/fir_top.sv ====
// FIR filter top level with plain lite and stream ports, memories and both blocks
`timescale 1ns/10ps

module fir_top import fir_pkg::*; (
  input  logic  axis_clk,
  input  logic  axis_rst_n,
  // lite write
  input  logic  awvalid,
  output logic  awready,
  input  addr_t awaddr,
  input  logic  wvalid,
  output logic  wready,
  input  data_t wdata,
  // lite read
  input  logic  arvalid,
  output logic  arready,
  input  addr_t araddr,
  output logic  rvalid,
  input  logic  rready,
  output data_t rdata,
  // sample input
  input  logic  ss_tvalid,
  output logic  ss_tready,
  input  data_t ss_tdata,
  // filter output
  output logic  sm_tvalid,
  input  logic  sm_tready,
  output data_t sm_tdata,
  output logic  sm_tlast
);

  fir_ram_if  coef_bus ();
  fir_ram_if  sample_bus ();
  fir_ctrl_if ctrl_bus ();

  fir_axil_regs regs_i (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .awvalid    (awvalid),
    .wvalid     (wvalid),
    .arvalid    (arvalid),
    .rready     (rready),
    .awaddr     (awaddr),
    .araddr     (araddr),
    .wdata      (wdata),
    .awready    (awready),
    .wready     (wready),
    .arready    (arready),
    .rvalid     (rvalid),
    .rdata      (rdata),
    .coef       (coef_bus.user),
    .ctrl       (ctrl_bus.regs)
  );

  fir_mac_engine engine_i (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .ss_tvalid  (ss_tvalid),
    .sm_tready  (sm_tready),
    .ss_tdata   (ss_tdata),
    .ss_tready  (ss_tready),
    .sm_tvalid  (sm_tvalid),
    .sm_tlast   (sm_tlast),
    .sm_tdata   (sm_tdata),
    .coef       (coef_bus.user),
    .samples    (sample_bus.user),
    .ctrl       (ctrl_bus.engine)
  );

  // coefficient store
  fir_ram coef_ram_i (
    .axis_clk (axis_clk),
    .port     (coef_bus.mem)
  );

  // sample ring
  fir_ram sample_ram_i (
    .axis_clk (axis_clk),
    .port     (sample_bus.mem)
  );

endmodule

// ==== sim/fir_sva.sv ====
// protocol assertions for the FIR filter top level and their bind into fir_top
`timescale 1ns/10ps

module fir_sva import fir_pkg::*; (
  input logic  axis_clk,
  input logic  axis_rst_n,
  input logic  awvalid,
  input logic  wvalid,
  input logic  awready,
  input logic  wready,
  input logic  rvalid,
  input logic  rready,
  input data_t rdata,
  input logic  ss_tready,
  input logic  sm_tvalid,
  input logic  sm_tready,
  input data_t sm_tdata,
  input logic  sm_tlast
);

  // write ready is a joint one-cycle pulse following both valids
  aw_w_ready_a: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    (awready || wready) |->
      awready && wready && $past(awvalid && wvalid) && !$past(awready))
    else $error("awready/wready not a joint pulse after awvalid and wvalid");

  // output word and last flag hold under back-pressure
  sm_hold_a: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast))
    else $error("sm_tvalid or its data changed before sm_tready");

  // one sample in flight, intake reopens after a start write or a non-final output
  intake_open_a: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    $rose(ss_tready) |-> $past(awready) || $past(sm_tvalid && sm_tready && !sm_tlast))
    else $error("ss_tready rose without a start write or an output handshake");

  // read data holds until taken
  r_hold_a: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("rvalid or rdata changed before rready");

endmodule

bind fir_top fir_sva sva_i (
  .axis_clk   (axis_clk),
  .axis_rst_n (axis_rst_n),
  .awvalid    (awvalid),
  .wvalid     (wvalid),
  .awready    (awready),
  .wready     (wready),
  .rvalid     (rvalid),
  .rready     (rready),
  .rdata      (rdata),
  .ss_tready  (ss_tready),
  .sm_tvalid  (sm_tvalid),
  .sm_tready  (sm_tready),
  .sm_tdata   (sm_tdata),
  .sm_tlast   (sm_tlast)
);

// ==== sim/fir_tb.sv ====
// FIR filter testbench with clock, reset, lite tasks, random runs, model and watchdog
`timescale 1ns/10ps

module fir_tb import fir_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY  = 2;
  localparam int NUM_RUNS   = 3;
  localparam int MIN_DATA   = 20;
  localparam int MAX_DATA   = 40;
  localparam int MAX_STALL  = 4;
  // cycles per sample for taps, drain, stall and handshake slack
  localparam int RUN_CYCLES = MAX_DATA * (MAX_TAPS + 3 + MAX_STALL + 4);
  localparam int LITE_CYCLES = (MAX_TAPS + 12) * 6;
  localparam int WATCHDOG_CYCLES = NUM_RUNS * (RUN_CYCLES + LITE_CYCLES) + 100;

  logic  axis_clk;
  logic  axis_rst_n;
  logic  awvalid;
  logic  awready;
  addr_t awaddr;
  logic  wvalid;
  logic  wready;
  data_t wdata;
  logic  arvalid;
  logic  arready;
  addr_t araddr;
  logic  rvalid;
  logic  rready;
  data_t rdata;
  logic  ss_tvalid;
  logic  ss_tready;
  data_t ss_tdata;
  logic  sm_tvalid;
  logic  sm_tready;
  data_t sm_tdata;
  logic  sm_tlast;

  int    seed;
  int    rd_count;
  int    err_value;
  int    err_other;
  data_t taps_model [MAX_TAPS];
  data_t xs [MAX_DATA];

  fir_top dut_i (.*);

  initial begin
    axis_clk = 1'b0;
    forever #(CLK_PERIOD / 2) axis_clk = ~axis_clk;
  end

  // lite write with valids held until awready/wready
  task automatic write_reg(input addr_t addr, input data_t value);
    awaddr  = addr;
    wdata   = value;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(posedge axis_clk);
    #(DRIVE_DLY);
    while (!awready) begin
      @(posedge axis_clk);
      #(DRIVE_DLY);
    end
    @(posedge axis_clk);
    #(DRIVE_DLY);
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  // lite read with one outstanding and rready held back a few cycles
  task automatic read_reg(input addr_t addr, output data_t value);
    int hold;
    hold = rd_count % (MAX_STALL + 1);
    rd_count++;
    araddr  = addr;
    arvalid = 1'b1;
    @(posedge axis_clk);
    #(DRIVE_DLY);
    while (!arready) begin
      @(posedge axis_clk);
      #(DRIVE_DLY);
    end
    @(posedge axis_clk);
    #(DRIVE_DLY);
    arvalid = 1'b0;
    while (!rvalid) begin
      @(posedge axis_clk);
      #(DRIVE_DLY);
    end
    repeat (hold) begin
      @(posedge axis_clk);
      #(DRIVE_DLY);
    end
    assert (rvalid) else begin
      err_other++;
      $display("rvalid dropped at %0t ns before rready was raised", $time);
    end
    value  = rdata;
    rready = 1'b1;
    @(posedge axis_clk);
    #(DRIVE_DLY);
    rready = 1'b0;
  endtask

  task automatic expect_reg(input addr_t addr, input data_t exp, input string name);
    data_t got;
    read_reg(addr, got);
    assert (got == exp) else begin
      err_value++;
      $display("[ERROR] %0t ns: rdata (%s) expected %h, got %h", $time, name, exp, got);
    end
  endtask

  // sum of h[k]*x[n-k] over k below coef_length and n+1
  function automatic data_t model_output(input int n, input int clen);
    data_t sum;
    int    k;
    sum = '0;
    for (k = 0; k < clen && k <= n; k++) begin
      sum = sum + taps_model[k] * xs[n - k];
    end
    return sum;
  endfunction

  task automatic drive_samples(input int count);
    int i;
    for (i = 0; i < count; i++) begin
      ss_tvalid = 1'b1;
      ss_tdata  = xs[i];
      while (!ss_tready) begin
        @(posedge axis_clk);
        #(DRIVE_DLY);
      end
      @(posedge axis_clk);
      #(DRIVE_DLY);
    end
    ss_tvalid = 1'b0;
  endtask

  // random sm_tready that stays low at most MAX_STALL cycles in a row
  task automatic collect_outputs(input int count, input int clen);
    int    n;
    int    stall;
    data_t exp;
    logic  exp_last;
    n = 0;
    stall = 0;
    while (n < count) begin
      if (stall >= MAX_STALL) sm_tready = 1'b1;
      else sm_tready = ($random(seed) & 1) != 0;
      stall = sm_tready ? 0 : stall + 1;
      if (sm_tvalid && sm_tready) begin
        exp = model_output(n, clen);
        exp_last = (n == count - 1);
        assert (sm_tdata == exp) else begin
          err_value++;
          $display("[ERROR] %0t ns: sm_tdata output %0d expected %h, got %h",
                   $time, n, exp, sm_tdata);
        end
        assert (sm_tlast == exp_last) else begin
          err_value++;
          $display("[ERROR] %0t ns: sm_tlast output %0d expected %b, got %b",
                   $time, n, exp_last, sm_tlast);
        end
        n++;
      end
      @(posedge axis_clk);
      #(DRIVE_DLY);
    end
    sm_tready = 1'b0;
  endtask

  task automatic run_filter(input int run_idx);
    int i;
    int clen;
    int dlen;
    clen = 1 + int'($unsigned($random(seed)) % MAX_TAPS);
    // last run covers the full memory depth
    if (run_idx == NUM_RUNS - 1) clen = MAX_TAPS;
    dlen = MIN_DATA + int'($unsigned($random(seed)) % (MAX_DATA - MIN_DATA + 1));
    for (i = 0; i < clen; i++) begin
      taps_model[i] = $random(seed);
      write_reg(TAP_BASE_ADDR + addr_t'(i * 4), taps_model[i]);
    end
    for (i = 0; i < dlen; i++) begin
      xs[i] = $random(seed);
    end
    write_reg(COEF_LEN_ADDR, data_t'(clen));
    write_reg(DATA_LEN_ADDR, data_t'(dlen));
    expect_reg(COEF_LEN_ADDR, data_t'(clen), "coef_length");
    expect_reg(DATA_LEN_ADDR, data_t'(dlen), "data_length");
    expect_reg(AP_CTRL_ADDR, 32'h4, "ap_ctrl before start");
    write_reg(AP_CTRL_ADDR, 32'h1);
    fork
      drive_samples(dlen);
      collect_outputs(dlen, clen);
      begin
        // config and taps are frozen while busy
        expect_reg(AP_CTRL_ADDR, 32'h0, "ap_ctrl while busy");
        write_reg(TAP_BASE_ADDR, ~taps_model[0]);
        write_reg(DATA_LEN_ADDR, 32'h1);
      end
    join
    // done lands one cycle after the last handshake
    repeat (2) begin
      @(posedge axis_clk);
      #(DRIVE_DLY);
    end
    assert (!sm_tvalid && !ss_tready) else begin
      err_other++;
      $display("run %0d: stream still active after the last output", run_idx);
    end
    expect_reg(AP_CTRL_ADDR, 32'h2, "ap_ctrl after run");
    expect_reg(AP_CTRL_ADDR, 32'h4, "ap_ctrl after done read");
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the test did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    seed = 12;
    rd_count = 0;
    err_value = 0;
    err_other = 0;
    axis_rst_n = 1'b0;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    ss_tvalid = 1'b0;
    ss_tdata = '0;
    sm_tready = 1'b0;
    repeat (8) @(posedge axis_clk);
    #(DRIVE_DLY);
    axis_rst_n = 1'b1;
    assert (!awready && !wready && !arready && !rvalid && !ss_tready && !sm_tvalid)
    else begin
      err_other++;
      $display("a handshake output is high after reset");
    end
    expect_reg(AP_CTRL_ADDR, 32'h4, "ap_ctrl after reset");
    expect_reg(COEF_LEN_ADDR, 32'h0, "coef_length after reset");
    expect_reg(DATA_LEN_ADDR, 32'h0, "data_length after reset");
    for (int r = 0; r < NUM_RUNS; r++) begin
      run_filter(r);
    end
    $display("summary: %0d value errors, %0d other errors", err_value, err_other);
    if (err_value == 0 && err_other == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== fir_filter.f ====
hdl/fir_pkg.sv
hdl/fir_ram_if.sv
hdl/fir_ctrl_if.sv
hdl/fir_ram.sv
hdl/fir_axil_regs.sv
hdl/fir_mac_engine.sv
hdl/fir_top.sv
sim/fir_sva.sv
sim/fir_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the FIR filter testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/fir_tb_sim

verilator --binary --timing --assert \
  --top-module fir_tb -o fir_tb_sim \
  -f fir_filter.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi
